// ==== logic/board_pkg.sv ====
// Shared widths and types for the board; segment tables assume common 0-F shapes, decimal point off
package board_pkg;

    // Number of display digits
    localparam int w_digit = 6;

    // Signed microphone sample
    typedef logic signed [23:0] sample_t;

    // Scanned segment bus, bit 7 is a, bit 0 is the decimal point h, active high
    typedef logic [7:0] seg_t;

    // One static display, bit 0 is a, bit 6 is g, active low
    typedef logic [6:0] hex_t;

    // Nibble to abcdefgh shapes
    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

// ==== logic/inmp441_mic_i2s_receiver.sv ====
// I2S master for one INMP441; clk_div must be even and at least 2, only the left 24 bits are kept
`timescale 1ns/10ps

module inmp441_mic_i2s_receiver
#(
    parameter int clk_div = 8
)
(
    input  logic               clk,
    input  logic               rst,
    output logic               sck,
    output logic               ws,
    input  logic               sd,
    output board_pkg::sample_t sample,
    output logic               sample_valid
);

    localparam int w_div = $clog2(clk_div);

    logic [w_div - 1:0] div_cnt;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         bit_cnt;
    logic               ws_rise;
    board_pkg::sample_t shift_reg;

    // --------------------
    // Serial clock divider

    // sck goes high half way through the period and low at its end
    assign sck_rise = (div_cnt == w_div'(clk_div / 2 - 1));
    assign sck_fall = (div_cnt == w_div'(clk_div - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else
        begin
            if (sck_fall)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            if (sck_rise)
                sck <= 1'b1;
            else if (sck_fall)
                sck <= 1'b0;
        end
    end

    // --------------------
    // Frame position, 64 sck periods per frame

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;
    end

    // Upper half of the frame is the right channel
    assign ws      = bit_cnt[5];
    assign ws_rise = sck_fall && (bit_cnt == 6'd31);

    // MSB arrives one period after ws falls
    always_ff @(posedge clk)
    begin
        if (sck_rise && (bit_cnt >= 6'd1) && (bit_cnt <= 6'd24))
            shift_reg <= {shift_reg[22:0], sd};
    end

    // --------------------
    // Sample output

    always_ff @(posedge clk)
    begin
        if (ws_rise)
            sample <= shift_reg;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sample_valid <= 1'b0;
        else
            sample_valid <= ws_rise;
    end

endmodule

// ==== logic/seven_segment_scanner.sv ====
// Dynamic display scanner; each digit stays scan_period clk cycles, no decimal points are lit
`timescale 1ns/10ps

module seven_segment_scanner
#(
    parameter int scan_period = 16
)
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [4 * board_pkg::w_digit - 1:0] value,
    output board_pkg::seg_t                 abcdefgh,
    output logic [board_pkg::w_digit - 1:0] digit
);

    localparam int w_cnt = (scan_period > 1) ? $clog2(scan_period) : 1;

    logic [w_cnt - 1:0]              dwell_cnt;
    logic                            dwell_end;
    logic [board_pkg::w_digit - 1:0] digit_next;
    logic [3:0]                      nibble;

    // --------------------
    // Digit rotation

    assign dwell_end = (dwell_cnt == w_cnt'(scan_period - 1));

    always_comb
    begin
        if (dwell_end)
            digit_next = {digit[board_pkg::w_digit - 2:0], digit[board_pkg::w_digit - 1]};
        else
            digit_next = digit;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dwell_cnt <= '0;
            digit     <= board_pkg::w_digit'(1);
        end
        else
        begin
            if (dwell_end)
                dwell_cnt <= '0;
            else
                dwell_cnt <= dwell_cnt + 1'b1;

            digit <= digit_next;
        end
    end

    // --------------------
    // Segment encoding

    // Nibble for the position that digit holds next cycle
    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < board_pkg::w_digit; i++)
        begin
            if (digit_next[i])
                nibble = value[4 * i +: 4];
        end
    end

    // Registered together with digit so both stay aligned
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            abcdefgh <= '0;
        else
            abcdefgh <= board_pkg::hex_to_seg(nibble);
    end

endmodule

// ==== logic/lab_top.sv ====
// Level meter core; freeze holds the shown sample, the LED bar only looks at magnitude bits 22..19
`timescale 1ns/10ps

module lab_top
#(
    parameter int scan_period = 16
)
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            freeze,
    input  board_pkg::sample_t              sample,
    input  logic                            sample_valid,
    output logic [9:0]                      led,
    output board_pkg::seg_t                 abcdefgh,
    output logic [board_pkg::w_digit - 1:0] digit
);

    board_pkg::sample_t disp;
    logic [22:0]        mag;
    logic [3:0]         level;
    logic [9:0]         led_next;

    // Displayed sample, held while frozen
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            disp <= '0;
        else if (sample_valid && !freeze)
            disp <= sample;
    end

    // --------------------
    // LED bar

    // Most negative sample saturates to full scale
    always_comb
    begin
        if (disp == 24'sh80_0000)
            mag = '1;
        else if (disp[23])
            mag = 23'(-disp);
        else
            mag = disp[22:0];
    end

    assign level = (mag[22:19] > 4'd10) ? 4'd10 : mag[22:19];

    always_comb
    begin
        for (int i = 0; i < 10; i++)
            led_next[i] = (i < level);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            led <= '0;
        else
            led <= led_next;
    end

    // --------------------
    // Hex digits of the displayed sample

    seven_segment_scanner
    #(
        .scan_period ( scan_period )
    )
    i_scanner
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .value    ( disp     ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// ==== logic/static_hex_latch.sv ====
// Turns the scanned segment bus into six sticky active-low displays; the decimal point is dropped
`timescale 1ns/10ps

module static_hex_latch
(
    input  logic                            clk,
    input  logic                            rst,
    input  board_pkg::seg_t                 abcdefgh,
    input  logic [board_pkg::w_digit - 1:0] digit,
    output board_pkg::hex_t                 hex0,
    output board_pkg::hex_t                 hex1,
    output board_pkg::hex_t                 hex2,
    output board_pkg::hex_t                 hex3,
    output board_pkg::hex_t                 hex4,
    output board_pkg::hex_t                 hex5
);

    board_pkg::seg_t hgfedcba;
    board_pkg::hex_t hex_new;
    board_pkg::hex_t hex_q [board_pkg::w_digit];

    // Segment a moves to bit 0
    always_comb
    begin
        for (int i = 0; i < $bits(board_pkg::seg_t); i++)
            hgfedcba[i] = abcdefgh[$bits(board_pkg::seg_t) - 1 - i];
    end

    assign hex_new = ~hgfedcba[6:0];

    // --------------------
    // Sticky display registers

    // Each display keeps its pattern while other digits are scanned
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < board_pkg::w_digit; i++)
                hex_q[i] <= '1;
        end
        else
        begin
            for (int i = 0; i < board_pkg::w_digit; i++)
            begin
                if (digit[i])
                    hex_q[i] <= hex_new;
            end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

endmodule

// ==== logic/board_top.sv ====
// Board wrapper for one INMP441 on the left channel; key_n is active low, displays are active low
`timescale 1ns/10ps

module board_top
#(
    parameter int clk_div     = 8,
    parameter int scan_period = 16
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            key_n,
    input  logic            mic_sd,
    output logic            mic_sck,
    output logic            mic_ws,
    output logic [9:0]      led,
    output board_pkg::hex_t hex0,
    output board_pkg::hex_t hex1,
    output board_pkg::hex_t hex2,
    output board_pkg::hex_t hex3,
    output board_pkg::hex_t hex4,
    output board_pkg::hex_t hex5
);

    // --------------------
    // Internal wires

    logic                            freeze;
    board_pkg::sample_t              sample;
    logic                            sample_valid;
    board_pkg::seg_t                 abcdefgh;
    logic [board_pkg::w_digit - 1:0] digit;

    // Key is pressed when low
    assign freeze = ~key_n;

    // --------------------
    // Microphone

    inmp441_mic_i2s_receiver
    #(
        .clk_div ( clk_div )
    )
    i_microphone
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .sd           ( mic_sd       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    // --------------------
    // Meter core

    lab_top
    #(
        .scan_period ( scan_period )
    )
    i_lab_top
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .freeze       ( freeze       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .led          ( led          ),
        .abcdefgh     ( abcdefgh     ),
        .digit        ( digit        )
    );

    // --------------------
    // Static displays

    static_hex_latch i_hex_latch
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .hex0     ( hex0     ),
        .hex1     ( hex1     ),
        .hex2     ( hex2     ),
        .hex3     ( hex3     ),
        .hex4     ( hex4     ),
        .hex5     ( hex5     )
    );

endmodule

// ==== test/board_top_tb.sv ====
// Emulates one INMP441 from test/board_top_golden.txt; run from the project root, frames start at reset
`timescale 1ns/10ps

module board_top_tb;

    localparam int clk_div      = 8;
    localparam int scan_period  = 16;
    localparam int settle_bound = 1 + 2 + 6 * scan_period + 2;

    logic            clk;
    logic            rst;
    logic            key_n;
    logic            mic_sd;
    logic            mic_sck;
    logic            mic_ws;
    logic [9:0]      led;
    board_pkg::hex_t hex0;
    board_pkg::hex_t hex1;
    board_pkg::hex_t hex2;
    board_pkg::hex_t hex3;
    board_pkg::hex_t hex4;
    board_pkg::hex_t hex5;

    int     value_errors;
    int     other_errors;
    integer seed;

    board_top
    #(
        .clk_div     ( clk_div     ),
        .scan_period ( scan_period )
    )
    i_board_top
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .key_n   ( key_n   ),
        .mic_sd  ( mic_sd  ),
        .mic_sck ( mic_sck ),
        .mic_ws  ( mic_ws  ),
        .led     ( led     ),
        .hex0    ( hex0    ),
        .hex1    ( hex1    ),
        .hex2    ( hex2    ),
        .hex3    ( hex3    ),
        .hex4    ( hex4    ),
        .hex5    ( hex5    )
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // Display model

    // Active-low pattern with segment a in bit 0
    function automatic board_pkg::hex_t hex_pattern(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    function automatic board_pkg::hex_t actual_hex(input int i);
        case (i)
            0: return hex0;
            1: return hex1;
            2: return hex2;
            3: return hex3;
            4: return hex4;
            default: return hex5;
        endcase
    endfunction

    function automatic bit displays_match(input logic [23:0] disp, input logic [9:0] exp_led);
        bit ok;
        ok = (led === exp_led);
        for (int i = 0; i < board_pkg::w_digit; i++)
            ok = ok && (actual_hex(i) === hex_pattern(disp[4 * i +: 4]));
        return ok;
    endfunction

    task automatic check_hex(input string name, input board_pkg::hex_t exp, board_pkg::hex_t act);
        if (act !== exp)
        begin
            value_errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_led(input logic [9:0] exp, input logic [9:0] act);
        if (act !== exp)
        begin
            value_errors++;
            $display("FAILED at %0t: led expected %h, got %h", $time, exp, act);
        end
    endtask

    task automatic check_displays(input logic [23:0] disp, input logic [9:0] exp_led);
        for (int i = 0; i < board_pkg::w_digit; i++)
            check_hex($sformatf("hex%0d", i), hex_pattern(disp[4 * i +: 4]), actual_hex(i));
        check_led(exp_led, led);
    endtask

    // --------------------
    // Microphone side

    task automatic wait_sck_fall();
        logic prev;
        prev = mic_sck;
        for (int n = 0; n < 2 * clk_div + 4; n++)
        begin
            @(negedge clk);
            if (prev && !mic_sck)
                return;
            prev = mic_sck;
        end
        other_errors++;
        $display("mic_sck stopped toggling at %0t", $time);
    endtask

    // Slot 1 carries the left MSB, slot 33 the right MSB, slot 64 wraps to 0
    task automatic play_frame(input logic [23:0] left, input logic [31:0] right);
        for (int slot = 1; slot <= 64; slot++)
        begin
            wait_sck_fall();
            if (slot <= 24)
                mic_sd = left[24 - slot];
            else if (slot >= 33)
                mic_sd = right[64 - slot];
            else
                mic_sd = 1'b0;
        end
    endtask

    task automatic check_frame(input logic [23:0] disp, input logic [9:0] exp_led,
                               input bit steady);
        logic prev;
        bit   rose;
        bit   settled;
        prev    = mic_ws;
        rose    = 1'b0;
        settled = 1'b0;
        for (int n = 0; n < 64 * clk_div + 8; n++)
        begin
            @(negedge clk);
            rose = !prev && mic_ws;
            prev = mic_ws;
            if (rose)
                break;
        end
        if (!rose)
        begin
            other_errors++;
            $display("mic_ws never rose before %0t", $time);
            return;
        end
        // An unchanged value must hold on every cycle of the bound
        for (int n = 0; n < settle_bound; n++)
        begin
            @(negedge clk);
            if (steady)
            begin
                if (!displays_match(disp, exp_led))
                    break;
            end
            else if (displays_match(disp, exp_led))
            begin
                settled = 1'b1;
                break;
            end
        end
        if (!steady && !settled)
        begin
            other_errors++;
            $display("display did not settle on %h by %0t", disp, $time);
        end
        check_displays(disp, exp_led);
    endtask

    // --------------------
    // Main sequence

    initial
    begin
        string       line;
        int          fd;
        int          cases;
        logic [23:0] left;
        logic [31:0] filler;
        logic [31:0] right;
        logic        freeze_flag;
        logic [23:0] exp_disp;
        logic [9:0]  exp_led;
        logic [23:0] last_disp;

        rst          = 1'b1;
        key_n        = 1'b1;
        mic_sd       = 1'b0;
        value_errors = 0;
        other_errors = 0;
        seed         = 32'hdf18_d251;
        cases        = 0;
        last_disp    = '0;

        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < board_pkg::w_digit; i++)
            check_hex($sformatf("hex%0d", i), 7'h7f, actual_hex(i));
        check_led(10'h000, led);

        fd = $fopen("test/board_top_golden.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("could not open test/board_top_golden.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "/")
                    continue;
                if ($sscanf(line, "%h %h %h %h %h", left, filler, freeze_flag, exp_disp,
                            exp_led) != 5)
                begin
                    other_errors++;
                    $display("malformed golden line: %s", line);
                    continue;
                end
                right = filler ^ $random(seed);
                key_n = !freeze_flag;
                fork
                    play_frame(left, right);
                    check_frame(exp_disp, exp_led, exp_disp == last_disp);
                join
                last_disp = exp_disp;
                cases++;
            end
            $fclose(fd);
        end
        if (cases == 0)
        begin
            other_errors++;
            $display("no cases were read from the golden file");
        end

        $display("Cases: %0d, value errors: %0d, other failures: %0d, assertion failures: %0d",
                 cases, value_errors, other_errors, i_board_top.i_props.failures);
        if (value_errors + other_errors + i_board_top.i_props.failures == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== test/board_top_props.sv ====
// Bound into board_top; assumes one clk domain and a reset that spans at least two clk edges
`timescale 1ns/10ps

module board_top_props
(
    input logic            clk,
    input logic            rst,
    input logic            mic_sck,
    input logic            mic_ws,
    input logic [9:0]      led,
    input board_pkg::hex_t hex0,
    input board_pkg::hex_t hex1,
    input board_pkg::hex_t hex2,
    input board_pkg::hex_t hex3,
    input board_pkg::hex_t hex4,
    input board_pkg::hex_t hex5
);

    // Failed assertions, read by the testbench
    int failures = 0;

    // --------------------
    // I2S timing

    ws_on_sck_fall: assert property (
        @(posedge clk) disable iff (rst)
        (mic_ws != $past(mic_ws)) |-> ($past(mic_sck) && !mic_sck)
    )
    else
    begin
        failures++;
        $error("mic_ws changed away from a mic_sck falling edge");
    end

    sck_low_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !mic_sck
    )
    else
    begin
        failures++;
        $error("mic_sck is not low after reset");
    end

    // --------------------
    // Reset values

    // Checked from the second reset clock on
    hex_blank_in_reset: assert property (
        @(posedge clk) (rst && $past(rst)) |-> ({hex0, hex1, hex2, hex3, hex4, hex5} == '1)
    )
    else
    begin
        failures++;
        $error("displays are not blank during reset");
    end

    led_off_in_reset: assert property (
        @(posedge clk) (rst && $past(rst)) |-> (led == '0)
    )
    else
    begin
        failures++;
        $error("led is not zero during reset");
    end

endmodule

bind board_top board_top_props i_props
(
    .clk     ( clk     ),
    .rst     ( rst     ),
    .mic_sck ( mic_sck ),
    .mic_ws  ( mic_ws  ),
    .led     ( led     ),
    .hex0    ( hex0    ),
    .hex1    ( hex1    ),
    .hex2    ( hex2    ),
    .hex3    ( hex3    ),
    .hex4    ( hex4    ),
    .hex5    ( hex5    )
);

// ==== sources.f ====
logic/board_pkg.sv
logic/inmp441_mic_i2s_receiver.sv
logic/seven_segment_scanner.sv
logic/lab_top.sv
logic/static_hex_latch.sv
logic/board_top.sv
test/board_top_tb.sv
test/board_top_props.sv

// ==== test/board_top_golden.txt ====
// left_sample right_filler freeze expected_display expected_led, all in hex
// freeze 1 holds key_n low for the whole frame
000000 00000000 0 000000 000
123456 a5a5a5a5 0 123456 003
7fffff 00000000 0 7fffff 3ff
800001 ffffffff 0 800001 3ff
800000 12345678 0 800000 3ff
0a5000 00000000 0 0a5000 001
f00000 0f0f0f0f 0 f00000 003
400000 00000000 0 400000 0ff
480000 00000000 0 480000 1ff
500000 00000000 0 500000 3ff
c00000 00000000 0 c00000 0ff
abcdef 00000000 1 c00000 0ff
3c1d2e 00000000 0 3c1d2e 07f
3c1d2e ffffffff 0 3c1d2e 07f
3c1d2e 5a5a5a5a 0 3c1d2e 07f
000000 00000000 0 000000 000
